// File: build.f
+incdir+logic
logic/mips_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/naive_mips_top.sv
verification/tb_memory.sv
verification/tb_top.sv

// File: logic/decode_stage.sv
`include "mips_defs.svh"
`default_nettype none

module decode_stage (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire mips_pkg::word_t     fetch_inst_i,
    input  wire mips_pkg::word_t     fetch_pc_i,
    input  wire logic                dbus_stall_i,
    input  wire mips_pkg::fwd_t      ex_fwd_i,
    input  wire mips_pkg::fwd_t      mem_fwd_i,
    input  wire mips_pkg::wb_req_t   wb_i,
    output logic                     fetch_hold_o,
    output logic                     branch_taken_o,
    output mips_pkg::word_t          branch_target_o,
    output mips_pkg::ex_req_t        ex_req_o
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      rs_value;
    word_t      rt_value;
    word_t      regs [`MIPS_NUM_REGS];
    logic       uses_rs;
    logic       uses_rt;
    logic       is_beq;
    logic       is_bne;
    logic       load_use;
    ex_req_t    ex_req_d;
    ex_req_t    ex_req_q;

    assign opcode   = fetch_inst_i[31:26];
    assign rs       = fetch_inst_i[25:21];
    assign rt       = fetch_inst_i[20:16];
    assign rd       = fetch_inst_i[15:11];
    assign funct    = fetch_inst_i[5:0];
    assign imm_sext = {{16{fetch_inst_i[15]}}, fetch_inst_i[15:0]};
    assign imm_zext = {16'h0000, fetch_inst_i[15:0]};

    always_ff @(posedge clk) begin
        if (wb_i.we && wb_i.dest != '0) begin
            regs[wb_i.dest] <= wb_i.data;
        end
    end

    // Youngest producer wins. WB doubles as the write-first bypass.
    function automatic word_t read_operand(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (ex_fwd_i.valid_write && ex_fwd_i.dest == addr) begin
            value = ex_fwd_i.value;
        end else if (mem_fwd_i.valid_write && mem_fwd_i.dest == addr) begin
            value = mem_fwd_i.value;
        end else if (wb_i.we && wb_i.dest == addr) begin
            value = wb_i.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs_value = read_operand(rs);
        rt_value = read_operand(rt);
    end

    always_comb begin
        ex_req_d            = '0;
        ex_req_d.op_a       = rs_value;
        ex_req_d.op_b       = imm_sext;
        ex_req_d.store_data = rt_value;
        ex_req_d.dest       = rt;
        uses_rs             = 1'b1;
        uses_rt             = 1'b0;
        is_beq              = 1'b0;
        is_bne              = 1'b0;
        case (opcode)
            `OPC_SPECIAL: begin
                ex_req_d.dest      = rd;
                ex_req_d.op_b      = rt_value;
                ex_req_d.reg_write = 1'b1;
                uses_rt            = 1'b1;
                case (funct)
                    `FN_ADDU: ex_req_d.alu_op = ALU_ADD;
                    `FN_SUBU: ex_req_d.alu_op = ALU_SUB;
                    `FN_AND:  ex_req_d.alu_op = ALU_AND;
                    `FN_OR:   ex_req_d.alu_op = ALU_OR;
                    `FN_XOR:  ex_req_d.alu_op = ALU_XOR;
                    `FN_SLT:  ex_req_d.alu_op = ALU_SLT;
                    default:  ex_req_d.reg_write = 1'b0;  // Outside the subset.
                endcase
            end
            `OPC_ADDIU: ex_req_d.reg_write = 1'b1;
            `OPC_ORI: begin
                ex_req_d.alu_op    = ALU_OR;
                ex_req_d.op_b      = imm_zext;
                ex_req_d.reg_write = 1'b1;
            end
            `OPC_LUI: begin
                ex_req_d.alu_op    = ALU_LUI;
                ex_req_d.op_b      = imm_zext;
                ex_req_d.reg_write = 1'b1;
                uses_rs            = 1'b0;
            end
            `OPC_LW: begin
                ex_req_d.mem_op    = MEM_LOAD;
                ex_req_d.reg_write = 1'b1;
            end
            `OPC_SW: begin
                ex_req_d.mem_op = MEM_STORE;
                uses_rt         = 1'b1;
            end
            `OPC_BEQ: begin
                is_beq  = 1'b1;
                uses_rt = 1'b1;
            end
            `OPC_BNE: begin
                is_bne  = 1'b1;
                uses_rt = 1'b1;
            end
            default: uses_rs = 1'b0;
        endcase
    end

    // A load in execute has no value yet for a consumer right behind it.
    assign load_use = ex_fwd_i.valid_write && ex_fwd_i.is_load && ex_fwd_i.dest != '0 &&
                      ((uses_rs && ex_fwd_i.dest == rs) || (uses_rt && ex_fwd_i.dest == rt));

    assign fetch_hold_o    = load_use || dbus_stall_i;
    assign branch_taken_o  = !load_use &&
                             ((is_beq && rs_value == rt_value) ||
                              (is_bne && rs_value != rt_value));
    assign branch_target_o = fetch_pc_i + 32'd4 + {imm_sext[29:0], 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_req_q <= '0;
        end else if (!dbus_stall_i) begin
            ex_req_q <= load_use ? '0 : ex_req_d;   // Bubble while the consumer waits.
        end
    end

    assign ex_req_o = ex_req_q;

    a_r0_constant: assert property (@(posedge clk) disable iff (!rst_n)
        $stable(regs[0]))
        else $error("register 0 was written");

    // One bubble later the load forwards its data from the memory stage.
    a_load_leaves_ex: assert property (@(posedge clk) disable iff (!rst_n)
        (load_use && !dbus_stall_i) |=> (mem_fwd_i.valid_write &&
                                         mem_fwd_i.dest == $past(ex_fwd_i.dest)))
        else $error("load did not reach the memory stage after the bubble");

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              dbus_stall_i,
    input  wire mips_pkg::ex_req_t ex_req_i,
    output mips_pkg::fwd_t         ex_fwd_o,
    output mips_pkg::mm_req_t      mm_req_o
);
    import mips_pkg::*;

    word_t   alu_result;
    word_t   mem_addr;
    word_t   result;
    mm_req_t mm_req_q;

    always_comb begin
        case (ex_req_i.alu_op)
            ALU_ADD: alu_result = ex_req_i.op_a + ex_req_i.op_b;
            ALU_SUB: alu_result = ex_req_i.op_a - ex_req_i.op_b;
            ALU_AND: alu_result = ex_req_i.op_a & ex_req_i.op_b;
            ALU_OR:  alu_result = ex_req_i.op_a | ex_req_i.op_b;
            ALU_XOR: alu_result = ex_req_i.op_a ^ ex_req_i.op_b;
            ALU_SLT: begin
                alu_result = {31'b0, $signed(ex_req_i.op_a) < $signed(ex_req_i.op_b)};
            end
            ALU_LUI: alu_result = {ex_req_i.op_b[15:0], 16'h0000};
            default: alu_result = '0;
        endcase
    end

    // Word address for LW and SW, base plus sign-extended offset.
    assign mem_addr = ex_req_i.op_a + ex_req_i.op_b;
    assign result   = (ex_req_i.mem_op == MEM_NONE) ? alu_result : mem_addr;

    always_comb begin
        ex_fwd_o.valid_write = ex_req_i.reg_write;
        ex_fwd_o.is_load     = (ex_req_i.mem_op == MEM_LOAD);  // Value is the address.
        ex_fwd_o.dest        = ex_req_i.dest;
        ex_fwd_o.value       = result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mm_req_q <= '0;
        end else if (!dbus_stall_i) begin
            mm_req_q.mem_op     <= ex_req_i.mem_op;
            mm_req_q.dest       <= ex_req_i.dest;
            mm_req_q.reg_write  <= ex_req_i.reg_write;
            mm_req_q.result     <= result;
            mm_req_q.store_data <= ex_req_i.store_data;
        end
    end

    assign mm_req_o = mm_req_q;

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
`include "mips_defs.svh"
`default_nettype none

module fetch_stage (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            hold_i,
    input  wire logic            branch_taken_i,
    input  wire mips_pkg::word_t branch_target_i,
    output mips_pkg::word_t      ibus_addr_o,
    input  wire mips_pkg::word_t ibus_rdata_i,
    output mips_pkg::word_t      fetch_inst_o,
    output mips_pkg::word_t      fetch_pc_o
);
    import mips_pkg::*;

    word_t pc_q;
    word_t id_inst_q;
    word_t id_pc_q;

    assign ibus_addr_o  = pc_q;
    assign fetch_inst_o = id_inst_q;
    assign fetch_pc_o   = id_pc_q;

    // The branch in decode redirects the fetch after its delay slot.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `MIPS_RESET_PC;
        end else if (!hold_i) begin
            if (branch_taken_i) begin
                pc_q <= branch_target_i;
            end else begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_inst_q <= '0;                  // All zero decodes as a NOP.
            id_pc_q   <= `MIPS_RESET_PC;
        end else if (!hold_i) begin
            id_inst_q <= ibus_rdata_i;
            id_pc_q   <= pc_q;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc_q[1:0] == 2'b00)
        else $error("fetch PC not word aligned: %h", pc_q);

endmodule

`default_nettype wire

// File: logic/memory_stage.sv
`default_nettype none

module memory_stage (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              dbus_stall_i,
    input  wire mips_pkg::mm_req_t mm_req_i,
    output mips_pkg::dbus_req_t    dbus_req_o,
    input  wire mips_pkg::word_t   dbus_rdata_i,
    output mips_pkg::fwd_t         mem_fwd_o,
    output mips_pkg::wb_req_t      wb_o
);
    import mips_pkg::*;

    word_t   result;
    wb_req_t wb_q;

    // Strobes are levels, held for as long as the access sits here.
    always_comb begin
        dbus_req_o.read   = (mm_req_i.mem_op == MEM_LOAD);
        dbus_req_o.write  = (mm_req_i.mem_op == MEM_STORE);
        dbus_req_o.addr   = mm_req_i.result;
        dbus_req_o.wrdata = mm_req_i.store_data;
    end

    assign result = (mm_req_i.mem_op == MEM_LOAD) ? dbus_rdata_i : mm_req_i.result;

    always_comb begin
        mem_fwd_o.valid_write = mm_req_i.reg_write;
        mem_fwd_o.is_load     = 1'b0;              // Load data is already selected.
        mem_fwd_o.dest        = mm_req_i.dest;
        mem_fwd_o.value       = result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else if (!dbus_stall_i) begin
            wb_q.we   <= mm_req_i.reg_write;
            wb_q.dest <= mm_req_i.dest;
            wb_q.data <= result;
        end
    end

    assign wb_o = wb_q;

    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dbus_req_o.read && dbus_req_o.write))
        else $error("dbus read and write both high");

    // The upstream registers must freeze too, or the request would move.
    a_req_stable_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_stall_i |=> $stable(dbus_req_o))
        else $error("dbus request changed during stall");

endmodule

`default_nettype wire

// File: logic/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH
`default_nettype none

// First fetch address after reset.
`define MIPS_RESET_PC 32'h0000_0000
`define MIPS_NUM_REGS 32

// Primary opcodes, instruction bits 31:26.
`define OPC_SPECIAL 6'b000000
`define OPC_BEQ     6'b000100
`define OPC_BNE     6'b000101
`define OPC_ADDIU   6'b001001
`define OPC_ORI     6'b001101
`define OPC_LUI     6'b001111
`define OPC_LW      6'b100011
`define OPC_SW      6'b101011

// Funct codes of SPECIAL, bits 5:0.
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_SLT  6'b101010

`default_nettype wire
`endif

// File: logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_LOAD, MEM_STORE
    } mem_op_t;

    typedef struct packed {
        alu_op_t   alu_op;
        mem_op_t   mem_op;
        reg_addr_t dest;
        logic      reg_write;
        word_t     op_a;
        word_t     op_b;
        word_t     store_data;
    } ex_req_t;

    typedef struct packed {
        mem_op_t   mem_op;
        reg_addr_t dest;
        logic      reg_write;
        word_t     result;       // ALU result or memory address.
        word_t     store_data;
    } mm_req_t;

    typedef struct packed {
        logic      we;
        reg_addr_t dest;
        word_t     data;
    } wb_req_t;

    // A forwarding source. is_load marks a value not yet available.
    typedef struct packed {
        logic      valid_write;
        logic      is_load;
        reg_addr_t dest;
        word_t     value;
    } fwd_t;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;
        word_t wrdata;
    } dbus_req_t;

endpackage

`default_nettype wire

// File: logic/naive_mips_top.sv
`default_nettype none

module naive_mips_top (
    input  wire logic            clk,
    input  wire logic            rst_n,
    output mips_pkg::word_t      ibus_addr_o,
    input  wire mips_pkg::word_t ibus_rdata_i,
    output mips_pkg::dbus_req_t  dbus_req_o,
    input  wire mips_pkg::word_t dbus_rdata_i,
    input  wire logic            dbus_stall_i
);
    import mips_pkg::*;

    word_t   fetch_inst;
    word_t   fetch_pc;
    logic    fetch_hold;
    logic    branch_taken;
    word_t   branch_target;
    ex_req_t ex_req;
    fwd_t    ex_fwd;
    mm_req_t mm_req;
    fwd_t    mem_fwd;
    wb_req_t wb_req;

    fetch_stage u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .hold_i          (fetch_hold),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .ibus_addr_o     (ibus_addr_o),
        .ibus_rdata_i    (ibus_rdata_i),
        .fetch_inst_o    (fetch_inst),
        .fetch_pc_o      (fetch_pc)
    );

    decode_stage u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_inst_i    (fetch_inst),
        .fetch_pc_i      (fetch_pc),
        .dbus_stall_i    (dbus_stall_i),
        .ex_fwd_i        (ex_fwd),
        .mem_fwd_i       (mem_fwd),
        .wb_i            (wb_req),
        .fetch_hold_o    (fetch_hold),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_req_o        (ex_req)
    );

    execute_stage u_execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .dbus_stall_i    (dbus_stall_i),
        .ex_req_i        (ex_req),
        .ex_fwd_o        (ex_fwd),
        .mm_req_o        (mm_req)
    );

    memory_stage u_memory (
        .clk             (clk),
        .rst_n           (rst_n),
        .dbus_stall_i    (dbus_stall_i),
        .mm_req_i        (mm_req),
        .dbus_req_o      (dbus_req_o),
        .dbus_rdata_i    (dbus_rdata_i),
        .mem_fwd_o       (mem_fwd),
        .wb_o            (wb_req)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f build.f

./obj_dir/Vtb_top 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    exit 1
fi
exit 0

// File: verification/tb_memory.sv
`default_nettype none

module tb_memory (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                stall_en_i,
    input  wire mips_pkg::word_t     ibus_addr_i,
    output mips_pkg::word_t          ibus_rdata_o,
    input  wire mips_pkg::dbus_req_t dbus_req_i,
    output mips_pkg::word_t          dbus_rdata_o,
    output logic                     dbus_stall_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    word_t       rom [256];
    word_t       ram [256];
    logic [31:0] rng;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Past the ROM the core only sees NOPs.
    assign ibus_rdata_o = (ibus_addr_i[31:10] == '0) ? rom[ibus_addr_i[9:2]] : '0;
    assign dbus_rdata_o = dbus_req_i.read ? ram[dbus_req_i.addr[9:2]] : '0;  // Data only on a read.

    always @(posedge clk) begin
        if (rst_n && dbus_req_i.write && !dbus_stall_o) begin
            ram[dbus_req_i.addr[9:2]] <= dbus_req_i.wrdata;
        end
    end

    // Roughly one stall cycle in four when enabled.
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rng          <= 32'd72;
            dbus_stall_o <= 1'b0;
        end else begin
            rng          <= xorshift(rng);
            dbus_stall_o <= stall_en_i && (rng[1:0] == 2'b00);
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_top.sv
`include "mips_defs.svh"
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        stall_en;
    logic        dbus_stall;
    word_t       ibus_addr;
    word_t       ibus_rdata;
    word_t       dbus_rdata;
    dbus_req_t   dbus_req;
    word_t       prog [256];
    int          prog_len;
    word_t       exp_addr [$];
    word_t       exp_data [$];
    int          store_idx;
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;
    logic [31:0] rng;
    logic [9:0]  next_addr;
    string       test_name;

    naive_mips_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .ibus_addr_o  (ibus_addr),
        .ibus_rdata_i (ibus_rdata),
        .dbus_req_o   (dbus_req),
        .dbus_rdata_i (dbus_rdata),
        .dbus_stall_i (dbus_stall)
    );

    tb_memory mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_en_i   (stall_en),
        .ibus_addr_i  (ibus_addr),
        .ibus_rdata_o (ibus_rdata),
        .dbus_req_i   (dbus_req),
        .dbus_rdata_o (dbus_rdata),
        .dbus_stall_o (dbus_stall)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t fill_word(input int idx);
        logic [7:0] i;
        i = idx[7:0];
        return {i, ~i, i ^ 8'h5a, 8'hc3};
    endfunction

    function automatic word_t rtype(input logic [5:0] fn, input int rd, input int rs, input int rt);
        return {`OPC_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic word_t itype(input logic [5:0] op, input int rt, input int rs,
                                    input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    task automatic emit(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic next_rand(output word_t r);
        rng = xorshift(rng);
        r   = rng;
    endtask

    task automatic emit_store(input int rt);
        emit(itype(`OPC_SW, rt, 0, {6'd0, next_addr}));
        next_addr = (next_addr == 10'h3fc) ? 10'h100 : next_addr + 10'd4;
    endtask

    task automatic load_const(input int r, input word_t v);
        emit(itype(`OPC_LUI, r, 0, v[31:16]));
        emit(itype(`OPC_ORI, r, r, v[15:0]));
    endtask

    task automatic seg_alu;
        word_t a;
        word_t b;
        logic [5:0] fns [6];
        fns = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT};
        for (int k = 0; k < 4; k++) begin
            next_rand(a);
            next_rand(b);
            load_const(1, a);
            load_const(2, b);
            for (int f = 0; f < 6; f++) begin
                emit(rtype(fns[f], 3, 1, 2));
                emit_store(3);
            end
            emit(itype(`OPC_ADDIU, 3, 1, b[15:0]));
            emit_store(3);
            emit(itype(`OPC_ORI, 3, 2, a[15:0]));
            emit_store(3);
            emit(itype(`OPC_LUI, 3, 0, b[31:16]));
            emit_store(3);
        end
    endtask

    // Operands at distance 1, 2 and 3 from their producers.
    task automatic seg_forward;
        word_t a;
        for (int k = 0; k < 3; k++) begin
            next_rand(a);
            emit(itype(`OPC_ADDIU, 4, 0, a[15:0]));
            emit(rtype(`FN_ADDU, 5, 4, 4));
            emit(rtype(`FN_SUBU, 6, 5, 4));
            emit(32'h0);
            emit(rtype(`FN_XOR, 7, 5, 6));
            emit(32'h0);
            emit(32'h0);
            emit_store(7);
            emit_store(6);
        end
    endtask

    task automatic seg_load_use;
        word_t a;
        for (int k = 0; k < 3; k++) begin
            next_rand(a);
            load_const(1, a);
            emit(itype(`OPC_SW, 1, 0, 16'h00f0));
            emit(itype(`OPC_LW, 2, 0, 16'h00f0));
            emit(rtype(`FN_ADDU, 3, 2, 1));
            emit_store(3);
            emit(itype(`OPC_LW, 9, 0, {8'd0, a[5:0], 2'b00}));  // Prefilled word.
            emit_store(9);
        end
    endtask

    // Branch, delay slot, skipped slot, target.
    task automatic emit_branch(input logic [5:0] op, input int rs, input int rt);
        emit(itype(op, rt, rs, 16'd2));
        emit_store(1);
        emit_store(10);
        emit_store(2);
    endtask

    task automatic seg_branch;
        word_t a;
        next_rand(a);
        load_const(1, a);
        emit(rtype(`FN_ADDU, 2, 1, 0));
        emit(itype(`OPC_ADDIU, 10, 1, 16'd1));
        emit_branch(`OPC_BEQ, 1, 2);
        emit_branch(`OPC_BEQ, 1, 10);
        emit_branch(`OPC_BNE, 1, 10);
        emit_branch(`OPC_BNE, 1, 2);
    endtask

    // Instruction-level model of the subset with one branch delay slot.
    task automatic run_model;
        word_t r [32];
        word_t dm [256];
        word_t pc;
        word_t npc;
        word_t nnpc;
        word_t inst;
        word_t a;
        word_t b;
        word_t se;
        word_t ze;
        int    steps;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) dm[i] = fill_word(i);
        exp_addr.delete();
        exp_data.delete();
        pc    = '0;
        npc   = 32'd4;
        steps = 0;
        while (pc < 32'(prog_len * 4) && steps < 4096) begin
            inst = prog[pc[9:2]];
            a    = r[inst[25:21]];
            b    = r[inst[20:16]];
            se   = {{16{inst[15]}}, inst[15:0]};
            ze   = {16'h0, inst[15:0]};
            nnpc = npc + 32'd4;
            case (inst[31:26])
                `OPC_SPECIAL: case (inst[5:0])
                    `FN_ADDU: r[inst[15:11]] = a + b;
                    `FN_SUBU: r[inst[15:11]] = a - b;
                    `FN_AND:  r[inst[15:11]] = a & b;
                    `FN_OR:   r[inst[15:11]] = a | b;
                    `FN_XOR:  r[inst[15:11]] = a ^ b;
                    `FN_SLT:  r[inst[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:  ;
                endcase
                `OPC_ADDIU: r[inst[20:16]] = a + se;
                `OPC_ORI:   r[inst[20:16]] = a | ze;
                `OPC_LUI:   r[inst[20:16]] = {inst[15:0], 16'h0};
                `OPC_LW:    r[inst[20:16]] = dm[(a + se) >> 2];
                `OPC_SW: begin
                    dm[(a + se) >> 2] = b;
                    exp_addr.push_back(a + se);
                    exp_data.push_back(b);
                end
                `OPC_BEQ: if (a == b) nnpc = pc + 32'd4 + (se << 2);
                `OPC_BNE: if (a != b) nnpc = pc + 32'd4 + (se << 2);
                default: ;
            endcase
            r[0]  = '0;
            pc    = npc;
            npc   = nnpc;
            steps++;
        end
    endtask

    // Each completed bus write must match the next expected store.
    always @(posedge clk) begin
        if (rst_n && dbus_req.write && !dbus_stall) begin
            if (store_idx < exp_addr.size()) begin
                assert (dbus_req.addr == exp_addr[store_idx] &&
                        dbus_req.wrdata == exp_data[store_idx])
                else begin
                    errors++;
                    $display("mismatch in %s: expected %h at %h, actual %h at %h", test_name,
                             exp_data[store_idx], exp_addr[store_idx],
                             dbus_req.wrdata, dbus_req.addr);
                end
            end else begin
                errors++;
                $display("test %s: store to %h beyond the expected list", test_name,
                         dbus_req.addr);
            end
            store_idx++;
        end
    end

    task automatic run_test(input string name, input logic [3:0] segs, input logic stalls);
        int err_before;
        int cycles;
        err_before = errors;
        test_name  = name;
        prog_len   = 0;
        next_addr  = 10'h100;
        if (segs[0]) seg_alu();
        if (segs[1]) seg_forward();
        if (segs[2]) seg_load_use();
        if (segs[3]) seg_branch();
        @(negedge clk);
        rst_n     = 1'b0;
        stall_en  = stalls;
        store_idx = 0;
        for (int i = 0; i < 256; i++) begin
            mem.rom[i] = (i < prog_len) ? prog[i] : '0;
            mem.ram[i] = fill_word(i);
        end
        run_model();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        assert (ibus_addr == `MIPS_RESET_PC && !dbus_req.read && !dbus_req.write)
        else begin
            errors++;
            $display("test %s: bus not idle or PC not at reset address after reset", name);
        end
        cycles = 0;
        while (store_idx < exp_addr.size() && cycles < 4000) begin
            @(negedge clk);
            cycles++;
        end
        if (store_idx < exp_addr.size()) begin
            timed_out = 1'b1;
            $display("test %s: timed out after %0d of %0d stores", name, store_idx,
                     exp_addr.size());
        end
        tests_run++;
        if (errors != err_before || timed_out) tests_failed++;
        $display("test %s done: %0d stores, %0d errors", name, store_idx, errors - err_before);
    endtask

    initial begin
        rst_n        = 1'b0;
        stall_en     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        store_idx    = 0;
        timed_out    = 1'b0;
        rng          = 32'd72;
        test_name    = "init";
        run_test("alu", 4'b0001, 1'b0);
        if (!timed_out) run_test("forward", 4'b0010, 1'b0);
        if (!timed_out) run_test("load_use", 4'b0100, 1'b0);
        if (!timed_out) run_test("branch", 4'b1000, 1'b0);
        if (!timed_out) run_test("stall", 4'b1111, 1'b1);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
